/* Bender.yml */
package:
  name: segmented_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/word_memory.sv
      - hdl/register_bank.sv
      - hdl/decode_unit.sv
      - hdl/execute_unit.sv
      - hdl/hazard_unit.sv
      - hdl/segmented_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/core_properties.sv
      - tests/core_tb.sv

/* hdl/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_e   alu_op,
    output logic              alu_src,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              branch,
    output logic              branch_ne
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // Sign-extended immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Main controller, unknown opcodes fall through as a bubble
    always_comb begin
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        imm        = '0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        case (opcode)
            rv_pkg::op_rtype: begin
                rs1       = instr[19:15];
                rs2       = instr[24:20];
                rd        = instr[11:7];
                reg_write = 1'b1;
            end
            rv_pkg::op_itype: begin
                rs1       = instr[19:15];
                rd        = instr[11:7];
                imm       = imm_i;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_load: begin
                rs1        = instr[19:15];
                rd         = instr[11:7];
                imm        = imm_i;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            rv_pkg::op_store: begin
                rs1       = instr[19:15];
                rs2       = instr[24:20];
                imm       = imm_s;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::op_branch: begin
                rs1       = instr[19:15];
                rs2       = instr[24:20];
                imm       = imm_b;
                branch    = 1'b1;
                // funct3 bit 0 separates BNE from BEQ
                branch_ne = funct3[0];
            end
            default: ;
        endcase
    end

    // ALU controller
    always_comb begin
        alu_op = rv_pkg::alu_add;
        if (opcode == rv_pkg::op_rtype || opcode == rv_pkg::op_itype) begin
            case (funct3)
                3'b000: begin
                    // Bit 30 only selects SUB on register-register ops
                    if (opcode == rv_pkg::op_rtype && instr[30])
                        alu_op = rv_pkg::alu_sub;
                    else
                        alu_op = rv_pkg::alu_add;
                end
                3'b010:  alu_op = rv_pkg::alu_slt;
                3'b100:  alu_op = rv_pkg::alu_xor;
                3'b110:  alu_op = rv_pkg::alu_or;
                3'b111:  alu_op = rv_pkg::alu_and;
                default: alu_op = rv_pkg::alu_add;
            endcase
        end else if (opcode == rv_pkg::op_branch) begin
            alu_op = rv_pkg::alu_sub;
        end
    end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  rv_pkg::word_t    operand_a,
    input  rv_pkg::word_t    operand_b,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    mem_result,
    input  rv_pkg::word_t    wb_result,
    input  rv_pkg::fwd_sel_e fwd_sel_a,
    input  rv_pkg::fwd_sel_e fwd_sel_b,
    input  rv_pkg::alu_op_e  alu_op,
    input  logic             alu_src,
    input  logic             branch,
    input  logic             branch_ne,
    output rv_pkg::word_t    alu_result,
    output rv_pkg::word_t    store_data,
    output logic             branch_taken
);

    rv_pkg::word_t src_a;
    rv_pkg::word_t reg_b;
    rv_pkg::word_t src_b;
    logic          equal;

    // Forwarding muxes
    always_comb begin
        case (fwd_sel_a)
            rv_pkg::fwd_mem: src_a = mem_result;
            rv_pkg::fwd_wb:  src_a = wb_result;
            default:         src_a = operand_a;
        endcase
        case (fwd_sel_b)
            rv_pkg::fwd_mem: reg_b = mem_result;
            rv_pkg::fwd_wb:  reg_b = wb_result;
            default:         reg_b = operand_b;
        endcase
    end

    assign src_b      = alu_src ? imm : reg_b;
    assign store_data = reg_b;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub: alu_result = src_a - src_b;
            rv_pkg::alu_and: alu_result = src_a & src_b;
            rv_pkg::alu_or:  alu_result = src_a | src_b;
            rv_pkg::alu_xor: alu_result = src_a ^ src_b;
            rv_pkg::alu_slt: alu_result = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
            default:         alu_result = src_a + src_b;
        endcase
    end

    // Branch compare uses the forwarded register values
    assign equal        = (src_a == reg_b);
    assign branch_taken = branch && (branch_ne ? !equal : equal);

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::reg_addr_t id_rs1,
    input  rv_pkg::reg_addr_t id_rs2,
    input  logic              mem_reg_write,
    input  logic              wb_reg_write,
    input  logic              ex_mem_read,
    input  logic              branch_taken,
    output rv_pkg::fwd_sel_e  fwd_sel_a,
    output rv_pkg::fwd_sel_e  fwd_sel_b,
    output logic              stall,
    output logic              flush
);

    logic load_use;

    // Youngest producer wins
    function automatic rv_pkg::fwd_sel_e pick_fwd(
        input rv_pkg::reg_addr_t src,
        input rv_pkg::reg_addr_t m_rd,
        input logic              m_we,
        input rv_pkg::reg_addr_t w_rd,
        input logic              w_we
    );
        if (src == '0)
            return rv_pkg::fwd_reg;
        if (m_we && m_rd == src)
            return rv_pkg::fwd_mem;
        if (w_we && w_rd == src)
            return rv_pkg::fwd_wb;
        return rv_pkg::fwd_reg;
    endfunction

    always_comb begin
        fwd_sel_a = pick_fwd(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
        fwd_sel_b = pick_fwd(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    end

    // Load result is only ready after MEM
    assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

endmodule

/* hdl/register_bank.sv */
`timescale 1ns/1ps

module register_bank (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rd_addr_a,
    input  rv_pkg::reg_addr_t rd_addr_b,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data,
    input  logic              wr_en,
    output rv_pkg::word_t     rd_data_a,
    output rv_pkg::word_t     rd_data_b
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

/* hdl/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and address width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// Memory depths in words
`define RV_IMEM_DEPTH 256
`define RV_DMEM_DEPTH 256

// Sequential fetch increment in bytes
`define RV_PC_STEP 4

// ADDI x0,x0,0, the bubble used by stall and flush
`define RV_NOP 32'h0000_0013

`endif

/* hdl/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

    // Word index widths of the two memories
    localparam int imem_aw = $clog2(`RV_IMEM_DEPTH);
    localparam int dmem_aw = $clog2(`RV_DMEM_DEPTH);

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [imem_aw-1:0]        imem_addr_t;
    typedef logic [dmem_aw-1:0]        dmem_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_e;

endpackage

/* hdl/segmented_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module segmented_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_wdata,
    output logic               wb_valid,
    output rv_pkg::reg_addr_t  wb_rd,
    output rv_pkg::word_t      wb_data
);

    // Fetch
    rv_pkg::word_t      pc;
    rv_pkg::imem_addr_t imem_rd_addr;
    rv_pkg::word_t      imem_rdata;

    // IF/ID
    rv_pkg::word_t if_id_instr;
    rv_pkg::word_t if_id_pc;

    // Decode outputs
    rv_pkg::reg_addr_t dec_rs1;
    rv_pkg::reg_addr_t dec_rs2;
    rv_pkg::reg_addr_t dec_rd;
    rv_pkg::word_t     dec_imm;
    rv_pkg::alu_op_e   dec_alu_op;
    logic              dec_alu_src;
    logic              dec_mem_read;
    logic              dec_mem_write;
    logic              dec_mem_to_reg;
    logic              dec_reg_write;
    logic              dec_branch;
    logic              dec_branch_ne;
    rv_pkg::word_t     rf_data_a;
    rv_pkg::word_t     rf_data_b;

    // ID/EX
    rv_pkg::word_t     id_ex_pc;
    rv_pkg::word_t     id_ex_rs1_data;
    rv_pkg::word_t     id_ex_rs2_data;
    rv_pkg::word_t     id_ex_imm;
    rv_pkg::reg_addr_t id_ex_rs1;
    rv_pkg::reg_addr_t id_ex_rs2;
    rv_pkg::reg_addr_t id_ex_rd;
    rv_pkg::alu_op_e   id_ex_alu_op;
    logic              id_ex_alu_src;
    logic              id_ex_mem_read;
    logic              id_ex_mem_write;
    logic              id_ex_mem_to_reg;
    logic              id_ex_reg_write;
    logic              id_ex_branch;
    logic              id_ex_branch_ne;

    // Execute and hazard control
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    store_data;
    rv_pkg::word_t    branch_target;
    logic             branch_taken;
    rv_pkg::fwd_sel_e fwd_sel_a;
    rv_pkg::fwd_sel_e fwd_sel_b;
    logic             stall;
    logic             flush;

    // EX/MEM
    rv_pkg::word_t     ex_mem_alu_result;
    rv_pkg::word_t     ex_mem_store_data;
    rv_pkg::reg_addr_t ex_mem_rd;
    logic              ex_mem_mem_write;
    logic              ex_mem_mem_to_reg;
    logic              ex_mem_reg_write;
    rv_pkg::word_t     dmem_rdata;

    // MEM/WB
    rv_pkg::word_t     mem_wb_alu_result;
    rv_pkg::word_t     mem_wb_load_data;
    rv_pkg::reg_addr_t mem_wb_rd;
    logic              mem_wb_mem_to_reg;
    logic              mem_wb_reg_write;
    rv_pkg::word_t     wb_value;

    // Program counter, branch redirect beats the stall hold
    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (flush)
            pc <= branch_target;
        else if (!stall)
            pc <= pc + `RV_PC_STEP;
    end

    // Loader port shares the fetch address
    assign imem_rd_addr = imem_we ? imem_addr : rv_pkg::imem_addr_t'(pc >> 2);

    word_memory #(.depth(`RV_IMEM_DEPTH)) imem (
        .clk   (clk),
        .we    (imem_we),
        .addr  (imem_rd_addr),
        .wdata (imem_wdata),
        .rdata (imem_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || flush)
            if_id_instr <= `RV_NOP;
        else if (!stall)
            if_id_instr <= imem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            if_id_pc <= pc;
    end

    decode_unit i_decode (
        .instr      (if_id_instr),
        .rs1        (dec_rs1),
        .rs2        (dec_rs2),
        .rd         (dec_rd),
        .imm        (dec_imm),
        .alu_op     (dec_alu_op),
        .alu_src    (dec_alu_src),
        .mem_read   (dec_mem_read),
        .mem_write  (dec_mem_write),
        .mem_to_reg (dec_mem_to_reg),
        .reg_write  (dec_reg_write),
        .branch     (dec_branch),
        .branch_ne  (dec_branch_ne)
    );

    register_bank i_regs (
        .clk       (clk),
        .rd_addr_a (dec_rs1),
        .rd_addr_b (dec_rs2),
        .wr_addr   (mem_wb_rd),
        .wr_data   (wb_value),
        .wr_en     (mem_wb_reg_write),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

    // ID/EX control, bubble on reset, stall or flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush || stall) begin
            id_ex_rs1        <= '0;
            id_ex_rs2        <= '0;
            id_ex_rd         <= '0;
            id_ex_alu_op     <= rv_pkg::alu_add;
            id_ex_alu_src    <= 1'b0;
            id_ex_mem_read   <= 1'b0;
            id_ex_mem_write  <= 1'b0;
            id_ex_mem_to_reg <= 1'b0;
            id_ex_reg_write  <= 1'b0;
            id_ex_branch     <= 1'b0;
            id_ex_branch_ne  <= 1'b0;
        end else begin
            id_ex_rs1        <= dec_rs1;
            id_ex_rs2        <= dec_rs2;
            id_ex_rd         <= dec_rd;
            id_ex_alu_op     <= dec_alu_op;
            id_ex_alu_src    <= dec_alu_src;
            id_ex_mem_read   <= dec_mem_read;
            id_ex_mem_write  <= dec_mem_write;
            id_ex_mem_to_reg <= dec_mem_to_reg;
            id_ex_reg_write  <= dec_reg_write;
            id_ex_branch     <= dec_branch;
            id_ex_branch_ne  <= dec_branch_ne;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc       <= if_id_pc;
        id_ex_rs1_data <= rf_data_a;
        id_ex_rs2_data <= rf_data_b;
        id_ex_imm      <= dec_imm;
    end

    hazard_unit i_hazard (
        .ex_rs1        (id_ex_rs1),
        .ex_rs2        (id_ex_rs2),
        .mem_rd        (ex_mem_rd),
        .wb_rd         (mem_wb_rd),
        .ex_rd         (id_ex_rd),
        .id_rs1        (dec_rs1),
        .id_rs2        (dec_rs2),
        .mem_reg_write (ex_mem_reg_write),
        .wb_reg_write  (mem_wb_reg_write),
        .ex_mem_read   (id_ex_mem_read),
        .branch_taken  (branch_taken),
        .fwd_sel_a     (fwd_sel_a),
        .fwd_sel_b     (fwd_sel_b),
        .stall         (stall),
        .flush         (flush)
    );

    execute_unit i_execute (
        .operand_a    (id_ex_rs1_data),
        .operand_b    (id_ex_rs2_data),
        .imm          (id_ex_imm),
        .mem_result   (ex_mem_alu_result),
        .wb_result    (wb_value),
        .fwd_sel_a    (fwd_sel_a),
        .fwd_sel_b    (fwd_sel_b),
        .alu_op       (id_ex_alu_op),
        .alu_src      (id_ex_alu_src),
        .branch       (id_ex_branch),
        .branch_ne    (id_ex_branch_ne),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .branch_taken (branch_taken)
    );

    assign branch_target = id_ex_pc + id_ex_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem_mem_write  <= 1'b0;
            ex_mem_mem_to_reg <= 1'b0;
            ex_mem_reg_write  <= 1'b0;
        end else begin
            ex_mem_mem_write  <= id_ex_mem_write;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
            ex_mem_reg_write  <= id_ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_alu_result <= alu_result;
        ex_mem_store_data <= store_data;
        ex_mem_rd         <= id_ex_rd;
    end

    // Byte address to word index
    word_memory #(.depth(`RV_DMEM_DEPTH)) dmem (
        .clk   (clk),
        .we    (ex_mem_mem_write),
        .addr  (rv_pkg::dmem_addr_t'(ex_mem_alu_result >> 2)),
        .wdata (ex_mem_store_data),
        .rdata (dmem_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb_mem_to_reg <= 1'b0;
            mem_wb_reg_write  <= 1'b0;
        end else begin
            mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
            mem_wb_reg_write  <= ex_mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_load_data  <= dmem_rdata;
        mem_wb_rd         <= ex_mem_rd;
    end

    assign wb_value = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_result;

    // Retire port, writes to x0 are not reported
    assign wb_valid = mem_wb_reg_write && (mem_wb_rd != '0);
    assign wb_rd    = mem_wb_rd;
    assign wb_data  = wb_value;

endmodule

/* hdl/word_memory.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module word_memory #(
    parameter int depth = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [`RV_XLEN-1:0]      wdata,
    output logic [`RV_XLEN-1:0]      rdata
);

    logic [`RV_XLEN-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    // Asynchronous read, new data visible after the write edge
    assign rdata = mem[addr];

endmodule

/* tb.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/word_memory.sv
hdl/register_bank.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/segmented_core.sv
tests/core_properties.sv
tests/core_tb.sv

/* tests/core_properties.sv */
`timescale 1ns/1ps

module core_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              wb_valid,
    input rv_pkg::reg_addr_t wb_rd,
    input logic              stall,
    input logic              flush,
    input rv_pkg::word_t     pc
);

    int fail_count = 0;

    // Reset empties the retire stage
    a_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid)
        else begin
            fail_count++;
            $error("wb_valid high in the cycle after reset");
        end

    a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
                                     wb_valid |-> wb_rd != '0)
        else begin
            fail_count++;
            $error("retirement reported for x0");
        end

    // Flush wins over a load-use stall
    a_stall_flush_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                                              !(stall && flush))
        else begin
            fail_count++;
            $error("stall and flush high together");
        end

    a_pc_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
                                         stall |=> $stable(pc))
        else begin
            fail_count++;
            $error("PC moved during a stall");
        end

endmodule

bind segmented_core core_properties i_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .stall    (stall),
    .flush    (flush),
    .pc       (pc)
);

/* tests/core_tb.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module core_tb;

    localparam int          num_tests   = 5;
    localparam int          cycle_limit = 200 * num_tests + 100;
    localparam logic [31:0] lfsr_taps   = 32'h8020_0003;

    // R-type funct3 codes
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    logic               clk;
    logic               rst_n;
    logic               imem_we;
    rv_pkg::imem_addr_t imem_addr;
    rv_pkg::word_t      imem_wdata;
    logic               wb_valid;
    rv_pkg::reg_addr_t  wb_rd;
    rv_pkg::word_t      wb_data;

    logic [31:0] prog [$];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [`RV_DMEM_DEPTH];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [4:0]  act_rd [$];
    logic [31:0] act_data [$];
    logic [31:0] lfsr_state;
    int          cycles;

    segmented_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %t %s expected %h actual %h",
                                $realtime, name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (i_dut.i_props.fail_count != 0)
            abort_run("A pipeline assertion failed, see the error reported above");
        else if (cycles >= cycle_limit)
            abort_run("Timeout: the core did not finish the tests within the cycle limit");
    end

    // Retire monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            act_rd.push_back(wb_rd);
            act_data.push_back(wb_data);
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ lfsr_taps;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // ne selects BNE, offset in bytes
    function automatic logic [31:0] enc_br(input logic ne, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 'x;
        endcase
    endfunction

    // ISA model, runs the program in order up to the halt branch
    task automatic run_model(input int halt_idx);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  rd;
        logic        wr;
        int          pc_idx;
        int          steps;
        pc_idx = 0;
        steps  = 0;
        exp_rd.delete();
        exp_data.delete();
        while (pc_idx != halt_idx) begin
            if (steps > 1000 || pc_idx < 0 || pc_idx >= prog.size())
                abort_run("Reference model ran outside the program or never reached its end");
            w      = prog[pc_idx];
            rd     = w[11:7];
            a      = model_regs[w[19:15]];
            b      = model_regs[w[24:20]];
            imm    = {{20{w[31]}}, w[31:20]};
            wr     = 1'b1;
            res    = '0;
            pc_idx = pc_idx + 1;
            case (w[6:0])
                7'b0110011: res = model_alu(w[14:12], w[30], a, b);
                7'b0010011: res = model_alu(w[14:12], 1'b0, a, imm);
                7'b0000011: res = model_mem[((a + imm) >> 2) % `RV_DMEM_DEPTH];
                7'b0100011: begin
                    wr  = 1'b0;
                    imm = {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[((a + imm) >> 2) % `RV_DMEM_DEPTH] = b;
                end
                7'b1100011: begin
                    wr  = 1'b0;
                    imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    // funct3 bit 0 inverts the equality test for BNE
                    if ((a == b) != w[12])
                        pc_idx = pc_idx - 1 + $signed(imm) / 4;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 5'd0) begin
                model_regs[rd] = res;
                exp_rd.push_back(rd);
                exp_data.push_back(res);
            end
            steps = steps + 1;
        end
    endtask

    // Load under reset, run, then compare the retire stream
    task automatic run_program(input string name);
        int halt_idx;
        int hold;
        halt_idx = prog.size();
        prog.push_back(enc_br(1'b0, 5'd0, 5'd0, 13'd0));
        prog.push_back(`RV_NOP);
        prog.push_back(`RV_NOP);
        run_model(halt_idx);
        hold = (prog.size() > 8) ? prog.size() : 8;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < hold; i++) begin
            imem_we    = (i < prog.size());
            imem_addr  = rv_pkg::imem_addr_t'(i);
            imem_wdata = (i < prog.size()) ? prog[i] : `RV_NOP;
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        act_rd.delete();
        act_data.delete();
        rst_n = 1'b1;
        while (act_rd.size() < exp_rd.size())
            @(negedge clk);
        repeat (20) @(negedge clk);
        if (act_rd.size() != exp_rd.size())
            abort_run($sformatf("%s: %0d instructions retired but %0d were expected",
                                name, act_rd.size(), exp_rd.size()));
        for (int i = 0; i < exp_rd.size(); i++) begin
            check($sformatf("%s wb_rd #%0d", name, i), exp_rd[i], act_rd[i]);
            check($sformatf("%s wb_data #%0d", name, i), exp_data[i], act_data[i]);
        end
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(enc_addi(5'd1, 5'd0, 12'd10));
        prog.push_back(enc_addi(5'd2, 5'd1, 12'd3));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd3, 5'd1, 5'd2));
        prog.push_back(enc_r(f3_add, 1'b1, 5'd4, 5'd3, 5'd1));
        prog.push_back(enc_r(f3_and, 1'b0, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_r(f3_or, 1'b0, 5'd6, 5'd5, 5'd2));
        prog.push_back(enc_r(f3_xor, 1'b0, 5'd7, 5'd6, 5'd4));
        prog.push_back(enc_r(f3_slt, 1'b0, 5'd8, 5'd4, 5'd7));
        prog.push_back(enc_addi(5'd9, 5'd0, -20));
        prog.push_back(enc_r(f3_slt, 1'b0, 5'd10, 5'd9, 5'd1));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd1, 5'd1, 5'd1));
        prog.push_back(enc_r(f3_add, 1'b1, 5'd11, 5'd9, 5'd1));
        run_program("forwarding");
    endtask

    task automatic test_load_store();
        prog.delete();
        prog.push_back(enc_addi(5'd1, 5'd0, 12'd100));
        prog.push_back(enc_addi(5'd2, 5'd0, -7));
        prog.push_back(enc_addi(5'd3, 5'd0, 12'd42));
        prog.push_back(enc_sw(5'd2, 5'd1, 12'd0));
        prog.push_back(enc_sw(5'd3, 5'd1, 12'd4));
        prog.push_back(enc_sw(5'd1, 5'd1, 12'd8));
        prog.push_back(enc_lw(5'd4, 5'd1, 12'd0));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_lw(5'd6, 5'd1, 12'd4));
        prog.push_back(enc_lw(5'd7, 5'd1, 12'd8));
        prog.push_back(enc_r(f3_add, 1'b1, 5'd8, 5'd7, 5'd6));
        prog.push_back(enc_lw(5'd9, 5'd1, 12'd0));
        prog.push_back(enc_sw(5'd9, 5'd1, 12'd12));
        prog.push_back(enc_lw(5'd10, 5'd1, 12'd12));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd11, 5'd10, 5'd10));
        run_program("load_store");
    endtask

    task automatic test_branches();
        prog.delete();
        prog.push_back(enc_addi(5'd1, 5'd0, 12'd5));
        prog.push_back(enc_addi(5'd2, 5'd0, 12'd5));
        prog.push_back(enc_addi(5'd3, 5'd0, 12'd9));
        // Taken BEQ skips two
        prog.push_back(enc_br(1'b0, 5'd1, 5'd2, 13'd12));
        prog.push_back(enc_addi(5'd4, 5'd0, 12'd1));
        prog.push_back(enc_addi(5'd4, 5'd0, 12'd2));
        prog.push_back(enc_addi(5'd5, 5'd0, 12'd3));
        prog.push_back(enc_br(1'b1, 5'd1, 5'd2, 13'd12));
        prog.push_back(enc_addi(5'd6, 5'd0, 12'd4));
        prog.push_back(enc_addi(5'd7, 5'd0, 12'd5));
        // Taken BNE skips two
        prog.push_back(enc_br(1'b1, 5'd1, 5'd3, 13'd12));
        prog.push_back(enc_addi(5'd8, 5'd0, 12'd6));
        prog.push_back(enc_addi(5'd8, 5'd0, 12'd7));
        prog.push_back(enc_addi(5'd9, 5'd0, 12'd8));
        prog.push_back(enc_br(1'b0, 5'd1, 5'd3, 13'd8));
        prog.push_back(enc_addi(5'd10, 5'd0, 12'd9));
        prog.push_back(enc_addi(5'd11, 5'd0, 12'd10));
        run_program("branches");
    endtask

    task automatic test_zero_register();
        prog.delete();
        prog.push_back(enc_addi(5'd0, 5'd0, 12'd5));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd5, 5'd0, 5'd0));
        prog.push_back(enc_addi(5'd6, 5'd0, 12'd7));
        prog.push_back(enc_r(f3_or, 1'b0, 5'd0, 5'd6, 5'd6));
        prog.push_back(enc_r(f3_add, 1'b0, 5'd7, 5'd0, 5'd6));
        prog.push_back(enc_addi(5'd0, 5'd6, 12'd1));
        prog.push_back(enc_r(f3_add, 1'b1, 5'd8, 5'd6, 5'd0));
        prog.push_back(enc_sw(5'd0, 5'd0, 12'd16));
        prog.push_back(enc_lw(5'd9, 5'd0, 12'd16));
        prog.push_back(enc_lw(5'd0, 5'd0, 12'd16));
        run_program("zero_register");
    endtask

    task automatic test_random_alu();
        logic [2:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        prog.delete();
        // Every register gets a known value first
        for (int r = 1; r < 32; r++)
            prog.push_back(enc_addi(5'(r), 5'd0, rand_bits(12)));
        for (int n = 0; n < 40; n++) begin
            kind = rand_bits(3);
            rd   = rand_bits(5);
            rs1  = rand_bits(5);
            rs2  = rand_bits(5);
            case (kind)
                3'd0:    prog.push_back(enc_r(f3_add, 1'b0, rd, rs1, rs2));
                3'd1:    prog.push_back(enc_r(f3_add, 1'b1, rd, rs1, rs2));
                3'd2:    prog.push_back(enc_r(f3_and, 1'b0, rd, rs1, rs2));
                3'd3:    prog.push_back(enc_r(f3_or, 1'b0, rd, rs1, rs2));
                3'd4:    prog.push_back(enc_r(f3_xor, 1'b0, rd, rs1, rs2));
                3'd5:    prog.push_back(enc_r(f3_slt, 1'b0, rd, rs1, rs2));
                default: prog.push_back(enc_addi(rd, rs1, rand_bits(12)));
            endcase
        end
        run_program("random_alu");
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        cycles     = 0;
        lfsr_state = 32'd80046;
        $timeformat(-9, 1, " ns", 0);
        for (int i = 0; i < 32; i++)
            model_regs[i] = (i == 0) ? '0 : 'x;
        repeat (8) @(posedge clk);
        test_forwarding();
        test_load_store();
        test_branches();
        test_zero_register();
        test_random_alu();
        if (i_dut.i_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("Pipeline assertions failed during the run");
            $display("test failed");
        end
        $finish;
    end

endmodule
